/* logic/dac_formatter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "qam_tx_macros.svh"

module dac_formatter
    import qam_types_pkg::*;
    import qam_ctrl_pkg::*;
(
    input  wire            sys_clk,
    input  wire            arst_n,
    input  wire            tx_enable,
    input  wire            sam_en,
    input  wire tap_sel_e  tap_sel,
    input  wire sample_t   filt_i,
    input  wire sample_t   filt_q,
    input  wire sample_t   up_i,
    input  wire sample_t   up_q,
    input  wire sample_t   sym_i,
    input  wire sample_t   sym_q,
    output dac_word_t      dac_a,
    output dac_word_t      dac_b,
    output logic           dac_wrt
);

    localparam dac_word_t MIDSCALE = dac_word_t'(1) << (`DAC_W - 1);

    sample_t sel_i;
    sample_t sel_q;
    logic    primed;
    logic    sam_d;

    // Top bits with inverted sign give offset binary
    function automatic dac_word_t to_offset(input sample_t s);
        return {~s[`SAMPLE_W-1], s[`SAMPLE_W-2 -: `DAC_W-1]};
    endfunction

    // Same tap point on both rails
    always_comb begin
        case (tap_sel)
            TAP_FILTERED: begin
                sel_i = filt_i;
                sel_q = filt_q;
            end
            TAP_UPSAMPLED: begin
                sel_i = up_i;
                sel_q = up_q;
            end
            TAP_SYMBOL: begin
                sel_i = sym_i;
                sel_q = sym_q;
            end
            default: begin
                sel_i = '0;
                sel_q = '0;
            end
        endcase
    end

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            primed  <= 1'b0;
            sam_d   <= 1'b0;
            dac_wrt <= 1'b0;
            dac_a   <= MIDSCALE;
            dac_b   <= MIDSCALE;
        end else begin
            // First sample after enable carries no symbol yet and is skipped
            primed  <= tx_enable && (primed || sam_en);
            // Filter output changes with sam_d
            sam_d   <= sam_en && primed;
            dac_wrt <= sam_d && tx_enable;
            if (sam_d && tx_enable) begin
                dac_a <= to_offset(sel_i);
                dac_b <= to_offset(sel_q);
            end
        end
    end

    // No write strobe once the transmitter is stopped
    a_wrt_enabled: assert property (@(posedge sys_clk) disable iff (!arst_n)
        dac_wrt |-> tx_enable);

endmodule

`default_nettype wire

/* logic/lfsr_symbol_source.sv */
`timescale 1ns/1ps
`default_nettype none
`include "qam_tx_macros.svh"

module lfsr_symbol_source
    import qam_types_pkg::*;
(
    input  wire               sys_clk,
    input  wire               arst_n,
    input  wire               sym_en,
    input  wire lfsr_state_t  seed,
    input  wire               seed_load,
    output symbol_t           symbol
);

    lfsr_state_t state;

    // Four Fibonacci steps, taps 22 and 21
    // New bit enters at bit 0 each step
    function automatic lfsr_state_t step_symbol(input lfsr_state_t s);
        lfsr_state_t r;
        r = s;
        for (int k = 0; k < $bits(symbol_t); k++) begin
            r = {r[`LFSR_W-2:0], r[`LFSR_W-1] ^ r[`LFSR_W-2]};
        end
        return r;
    endfunction

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= lfsr_state_t'(1);
        end else if (seed_load) begin
            // All-zero state would lock up
            state <= (seed == '0) ? lfsr_state_t'(1) : seed;
        end else if (sym_en) begin
            state <= step_symbol(state);
        end
    end

    // Four newest bits form the symbol
    assign symbol = state[$bits(symbol_t)-1:0];

endmodule

`default_nettype wire

/* logic/qam16_mapper.sv */
`timescale 1ns/1ps
`default_nettype none
`include "qam_tx_macros.svh"

module qam16_mapper
    import qam_types_pkg::*;
(
    input  wire           sys_clk,
    input  wire           arst_n,
    input  wire symbol_t  symbol,
    output sample_t       sym_i,
    output sample_t       sym_q
);

    localparam sample_t LVL_P1 = `SYMBOL_REF;
    localparam sample_t LVL_P3 = 3 * `SYMBOL_REF;
    localparam sample_t LVL_N1 = -`SYMBOL_REF;
    localparam sample_t LVL_N3 = -3 * `SYMBOL_REF;

    // Gray order 00 01 11 10 from -3 up to +3
    function automatic sample_t gray_level(input logic [1:0] bits);
        case (bits)
            2'b00:   return LVL_N3;
            2'b01:   return LVL_N1;
            2'b11:   return LVL_P1;
            default: return LVL_P3;
        endcase
    endfunction

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            sym_i <= '0;
            sym_q <= '0;
        end else begin
            sym_i <= gray_level(symbol[1:0]);
            sym_q <= gray_level(symbol[3:2]);
        end
    end

endmodule

`default_nettype wire

/* logic/qam_ctrl_pkg.sv */
`default_nettype none

package qam_ctrl_pkg;

    // Wishbone byte address and data word
    typedef logic [7:0]  wb_adr_t;
    typedef logic [31:0] wb_dat_t;

    // Chain point routed to the DAC rails
    typedef enum logic [1:0] {
        TAP_FILTERED  = 2'd0,
        TAP_UPSAMPLED = 2'd1,
        TAP_SYMBOL    = 2'd2,
        TAP_ZERO      = 2'd3
    } tap_sel_e;

    // Arithmetic right shift ahead of the pulse filter
    typedef logic [1:0] gain_shift_t;

    typedef enum logic {WB_IDLE, WB_ACK} wb_state_e;

endpackage

`default_nettype wire

/* logic/qam_tx_macros.svh */
`ifndef QAM_TX_MACROS_SVH
`define QAM_TX_MACROS_SVH

// Datapath widths
`define SAMPLE_W 18
`define DAC_W 14
`define LFSR_W 22

// sys_clk cycles per sample, samples per symbol
`define SAMPLE_DIV 4
`define SPS 4

// Unit constellation level, one eighth of full scale in 1s17
`define SYMBOL_REF 18'sd16384

// Register byte addresses
`define ADDR_CTRL 8'h00
`define ADDR_SEED 8'h04

`endif

/* logic/qam_tx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module qam_tx_top
    import qam_types_pkg::*;
    import qam_ctrl_pkg::*;
(
    input  wire             sys_clk,
    input  wire             arst_n,
    input  wire             wb_cyc,
    input  wire             wb_stb,
    input  wire             wb_we,
    input  wire wb_adr_t    wb_adr,
    input  wire wb_dat_t    wb_dat_w,
    output wire wb_dat_t    wb_dat_r,
    output wire             wb_ack,
    output wire dac_word_t  dac_a,
    output wire dac_word_t  dac_b,
    output wire             dac_wrt
);

    // Control
    logic        tx_enable;
    tap_sel_e    tap_sel;
    gain_shift_t gain_shift;
    lfsr_state_t seed;
    logic        seed_load;

    // Strobes
    logic   sam_en;
    logic   sym_en;
    phase_t phase;

    // Signal chain
    symbol_t symbol;
    sample_t sym_i;
    sample_t sym_q;
    sample_t filt_i;
    sample_t filt_q;
    sample_t up_i;
    sample_t up_q;

    tx_csr_wb u_csr (
        .sys_clk    (sys_clk),
        .arst_n     (arst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .tx_enable  (tx_enable),
        .tap_sel    (tap_sel),
        .gain_shift (gain_shift),
        .seed       (seed),
        .seed_load  (seed_load)
    );

    tx_timing_gen u_timing (
        .sys_clk   (sys_clk),
        .arst_n    (arst_n),
        .tx_enable (tx_enable),
        .sam_en    (sam_en),
        .sym_en    (sym_en),
        .phase     (phase)
    );

    lfsr_symbol_source u_lfsr (
        .sys_clk   (sys_clk),
        .arst_n    (arst_n),
        .sym_en    (sym_en),
        .seed      (seed),
        .seed_load (seed_load),
        .symbol    (symbol)
    );

    qam16_mapper u_mapper (
        .sys_clk (sys_clk),
        .arst_n  (arst_n),
        .symbol  (symbol),
        .sym_i   (sym_i),
        .sym_q   (sym_q)
    );

    // In-phase rail
    srrc_interp_filter rail_i (
        .sys_clk    (sys_clk),
        .arst_n     (arst_n),
        .tx_enable  (tx_enable),
        .sam_en     (sam_en),
        .phase      (phase),
        .gain_shift (gain_shift),
        .level      (sym_i),
        .filt       (filt_i),
        .upsampled  (up_i)
    );

    // Quadrature rail
    srrc_interp_filter rail_q (
        .sys_clk    (sys_clk),
        .arst_n     (arst_n),
        .tx_enable  (tx_enable),
        .sam_en     (sam_en),
        .phase      (phase),
        .gain_shift (gain_shift),
        .level      (sym_q),
        .filt       (filt_q),
        .upsampled  (up_q)
    );

    dac_formatter u_dac (
        .sys_clk   (sys_clk),
        .arst_n    (arst_n),
        .tx_enable (tx_enable),
        .sam_en    (sam_en),
        .tap_sel   (tap_sel),
        .filt_i    (filt_i),
        .filt_q    (filt_q),
        .up_i      (up_i),
        .up_q      (up_q),
        .sym_i     (sym_i),
        .sym_q     (sym_q),
        .dac_a     (dac_a),
        .dac_b     (dac_b),
        .dac_wrt   (dac_wrt)
    );

endmodule

`default_nettype wire

/* logic/qam_types_pkg.sv */
`default_nettype none
`include "qam_tx_macros.svh"

package qam_types_pkg;

    // Signed 1s17 sample on either rail
    typedef logic signed [`SAMPLE_W-1:0] sample_t;
    // Offset binary DAC code
    typedef logic [`DAC_W-1:0] dac_word_t;
    // Low pair picks I, high pair picks Q
    typedef logic [3:0] symbol_t;
    typedef logic [`LFSR_W-1:0] lfsr_state_t;
    // Sample slot inside a symbol
    typedef logic [1:0] phase_t;

    // SRRC pulse, four samples per symbol, peak on tap 8
    localparam sample_t srrc_taps [0:16] = '{
        18'sd1300, -18'sd2600, -18'sd7200, -18'sd8500, -18'sd2600,
        18'sd14400, 18'sd36700, 18'sd57000, 18'sd65536, 18'sd57000,
        18'sd36700, 18'sd14400, -18'sd2600, -18'sd8500, -18'sd7200,
        -18'sd2600, 18'sd1300
    };

endpackage

`default_nettype wire

/* logic/srrc_interp_filter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "qam_tx_macros.svh"

module srrc_interp_filter
    import qam_types_pkg::*;
    import qam_ctrl_pkg::*;
(
    input  wire               sys_clk,
    input  wire               arst_n,
    input  wire               tx_enable,
    input  wire               sam_en,
    input  wire phase_t       phase,
    input  wire gain_shift_t  gain_shift,
    input  wire sample_t      level,
    output sample_t           filt,
    output sample_t           upsampled
);

    localparam int NTAPS = $size(srrc_taps);
    // Symbols spanned by the pulse
    localparam int DEPTH = (NTAPS + `SPS - 1) / `SPS;
    // 2s34 products plus growth for the five-term sum
    localparam int ACC_W = 2 * `SAMPLE_W + 3;
    localparam int FRAC  = `SAMPLE_W - 1;

    sample_t                 line [DEPTH];
    sample_t                 line_next [DEPTH];
    sample_t                 level_sh;
    phase_t                  sub;
    logic signed [ACC_W-1:0] acc;

    // Mapper output settles one sample after sym_en
    // so timing slot 1 is slot 0 of the upsampled stream
    assign sub = phase - phase_t'(1);

    // Gain applied before the delay line
    assign level_sh = level >>> gain_shift;

    // New symbol enters at slot 0, line otherwise static
    always_comb begin
        line_next = line;
        if (sub == '0) begin
            line_next[0] = level_sh;
            for (int i = 1; i < DEPTH; i++) begin
                line_next[i] = line[i-1];
            end
        end
    end

    // Polyphase branch: taps sub, sub+4, sub+8 ...
    // Tap 16 exists only in branch 0
    always_comb begin
        acc = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (`SPS * i + int'(sub) < NTAPS) begin
                acc += srrc_taps[`SPS * i + int'(sub)] * line_next[i];
            end
        end
    end

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            line      <= '{default: '0};
            filt      <= '0;
            upsampled <= '0;
        end else if (!tx_enable) begin
            // Flush so a restart begins from silence
            line      <= '{default: '0};
            filt      <= '0;
            upsampled <= '0;
        end else if (sam_en) begin
            line <= line_next;
            // Truncate back to 1s17
            filt <= acc[FRAC + `SAMPLE_W - 1 : FRAC];
            // Zero-stuffed input seen by the filter
            upsampled <= (sub == '0) ? level_sh : '0;
        end
    end

    // Branch select must stay put between samples
    a_phase_on_sample: assert property (@(posedge sys_clk) disable iff (!arst_n)
        $changed(phase) |-> ($past(sam_en) || !$past(tx_enable)));

endmodule

`default_nettype wire

/* logic/tx_csr_wb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "qam_tx_macros.svh"

module tx_csr_wb
    import qam_ctrl_pkg::*;
    import qam_types_pkg::*;
(
    input  wire              sys_clk,
    input  wire              arst_n,
    input  wire              wb_cyc,
    input  wire              wb_stb,
    input  wire              wb_we,
    input  wire wb_adr_t     wb_adr,
    input  wire wb_dat_t     wb_dat_w,
    output wb_dat_t          wb_dat_r,
    output logic             wb_ack,
    output logic             tx_enable,
    output tap_sel_e         tap_sel,
    output gain_shift_t      gain_shift,
    output lfsr_state_t      seed,
    output logic             seed_load
);

    wb_state_e state;
    wb_dat_t   rd_data;
    logic      req;

    // New transfer only accepted from idle
    assign req = wb_cyc && wb_stb && (state == WB_IDLE);
    // Ack lasts exactly the one ACK cycle
    assign wb_ack = (state == WB_ACK);

    // Readback mux, unmapped addresses give zero
    always_comb begin
        case (wb_adr)
            `ADDR_CTRL: rd_data = wb_dat_t'({gain_shift, tap_sel, tx_enable});
            `ADDR_SEED: rd_data = wb_dat_t'(seed);
            default:    rd_data = '0;
        endcase
    end

    // Idle -> ack -> idle, forces a gap between acks
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= WB_IDLE;
        end else if (req) begin
            state <= WB_ACK;
        end else begin
            state <= WB_IDLE;
        end
    end

    // Register writes, taken on the request edge
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            tx_enable  <= 1'b0;
            tap_sel    <= TAP_FILTERED;
            gain_shift <= '0;
            seed       <= '0;
            seed_load  <= 1'b0;
        end else begin
            seed_load <= 1'b0;
            if (req && wb_we) begin
                case (wb_adr)
                    `ADDR_CTRL: begin
                        tx_enable  <= wb_dat_w[0];
                        tap_sel    <= tap_sel_e'(wb_dat_w[2:1]);
                        gain_shift <= wb_dat_w[4:3];
                    end
                    `ADDR_SEED: begin
                        seed <= wb_dat_w[`LFSR_W-1:0];
                        // Seed only reaches the LFSR while stopped
                        seed_load <= !tx_enable;
                    end
                    default: ;
                endcase
            end
        end
    end

    // Read data captured with the request, valid in the ack cycle
    always_ff @(posedge sys_clk) begin
        if (req && !wb_we) begin
            wb_dat_r <= rd_data;
        end
    end

    // Master must still hold cyc and stb whenever we ack
    a_ack_in_cycle: assert property (@(posedge sys_clk) disable iff (!arst_n)
        wb_ack |-> (wb_cyc && wb_stb));

endmodule

`default_nettype wire

/* logic/tx_timing_gen.sv */
`timescale 1ns/1ps
`default_nettype none
`include "qam_tx_macros.svh"

module tx_timing_gen
    import qam_types_pkg::*;
(
    input  wire     sys_clk,
    input  wire     arst_n,
    input  wire     tx_enable,
    output logic    sam_en,
    output logic    sym_en,
    output phase_t  phase
);

    localparam int DIV_W = $clog2(`SAMPLE_DIV);

    logic [DIV_W-1:0] div_cnt;
    logic             sam_due;

    // Divider parked at zero, so first enabled edge starts a sample
    assign sam_due = tx_enable && (div_cnt == '0);

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
            sam_en  <= 1'b0;
            sym_en  <= 1'b0;
            phase   <= '0;
        end else begin
            sam_en <= sam_due;
            // Symbol boundary at sample slot 0
            sym_en <= sam_due && (phase == '0);
            if (!tx_enable) begin
                div_cnt <= '0;
                phase   <= '0;
            end else begin
                if (div_cnt == DIV_W'(`SAMPLE_DIV - 1)) begin
                    div_cnt <= '0;
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
                // Phase names the slot of the upcoming sample
                if (sam_en) begin
                    phase <= (phase == phase_t'(`SPS - 1)) ? '0 : phase + 1'b1;
                end
            end
        end
    end

    // Symbol strobe always rides on a sample strobe
    a_sym_on_sam: assert property (@(posedge sys_clk) disable iff (!arst_n)
        sym_en |-> sam_en);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module qam_tx_tb -o qam_tx_sim

output=$(./obj_dir/qam_tx_sim 2>&1 || true)
echo "$output"

if grep -q "SIMULATION PASSED" <<< "$output"; then
    exit 0
fi
exit 1

/* tests/qam_tx_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "qam_tx_macros.svh"

module qam_tx_tb
    import qam_types_pkg::*;
    import qam_ctrl_pkg::*;
();

    localparam int CLK_PERIOD_NS = 20;
    localparam int ACK_LIMIT     = 16;
    localparam int MAX_SYMS      = 32;
    // 64 + 3 x 64 + 3 x 32 + 2 x 32 samples over all streams
    localparam int TOTAL_SAMPLES = 416;
    localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * `SAMPLE_DIV * `SPS + 2000;

    logic      sys_clk;
    logic      arst_n;
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    wb_adr_t   wb_adr;
    wb_dat_t   wb_dat_w;
    wb_dat_t   wb_dat_r;
    logic      wb_ack;
    dac_word_t dac_a;
    dac_word_t dac_b;
    logic      dac_wrt;

    int          checks = 0;
    int          errors = 0;
    string       test_name;
    // High while no DAC write may appear
    logic        quiet;
    logic [31:0] rng_state = 32'h5d66;
    symbol_t     sym_hist [MAX_SYMS];
    dac_word_t   exp_a [$];
    dac_word_t   exp_b [$];
    dac_word_t   got_a [$];
    dac_word_t   got_b [$];

    tb_clock_gen u_clk (
        .sys_clk (sys_clk),
        .arst_n  (arst_n)
    );

    qam_tx_top dut (
        .sys_clk  (sys_clk),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .dac_a    (dac_a),
        .dac_b    (dac_b),
        .dac_wrt  (dac_wrt)
    );

    // Stimulus LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = rng_state[31] ^ rng_state[21] ^ rng_state[1] ^ rng_state[0];
            rng_state = {rng_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
        end
    endtask

    // Symbol stream of the transmit LFSR, four new bits per symbol
    task automatic fill_symbols(input lfsr_state_t seed, input int count);
        lfsr_state_t s;
        symbol_t     sym;
        logic        fb;
        // Zero seed behaves as one
        s = (seed == '0) ? lfsr_state_t'(1) : seed;
        for (int n = 0; n < count; n++) begin
            sym = '0;
            for (int b = 0; b < 4; b++) begin
                fb = s[`LFSR_W-1] ^ s[`LFSR_W-2];
                s = {s[`LFSR_W-2:0], fb};
                sym = {sym[2:0], fb};
            end
            sym_hist[n] = sym;
        end
    endtask

    // Gray level of one rail of symbol n, then the gain shift
    function automatic int rail_level(input int n, input logic q_rail,
                                      input gain_shift_t shift);
        logic [1:0] pair;
        int         lvl;
        pair = q_rail ? sym_hist[n][3:2] : sym_hist[n][1:0];
        case (pair)
            2'b00:   lvl = -3;
            2'b01:   lvl = -1;
            2'b11:   lvl = 1;
            default: lvl = 3;
        endcase
        lvl = lvl * int'(`SYMBOL_REF);
        return lvl >>> shift;
    endfunction

    // Expected DAC code of output sample k on one rail
    function automatic dac_word_t ref_dac_word(input int k, input logic q_rail,
                                               input tap_sel_e tap, input gain_shift_t shift);
        longint             acc;
        int                 m;
        logic [`SAMPLE_W-1:0] s;
        acc = 0;
        case (tap)
            TAP_FILTERED: begin
                // Convolution with the zero-stuffed level stream
                for (int j = 0; j < 17; j++) begin
                    m = k - j;
                    if (m >= 0 && m % `SPS == 0) begin
                        acc += longint'(srrc_taps[j]) * rail_level(m / `SPS, q_rail, shift);
                    end
                end
                // Floor back to 1s17
                acc = acc >>> (`SAMPLE_W - 1);
            end
            TAP_UPSAMPLED: acc = (k % `SPS == 0) ? rail_level(k / `SPS, q_rail, shift) : 0;
            TAP_SYMBOL:    acc = rail_level(k / `SPS, q_rail, 2'd0);
            default:       acc = 0;
        endcase
        s = acc[`SAMPLE_W-1:0];
        // Top bits, sign flipped into offset binary
        return s[`SAMPLE_W-1 -: `DAC_W] ^ dac_word_t'(1 << (`DAC_W - 1));
    endfunction

    function automatic wb_dat_t ctrl_word(input logic en, input tap_sel_e tap,
                                          input gain_shift_t shift);
        return wb_dat_t'({shift, tap, en});
    endfunction

    // One classic Wishbone transfer, held until ack
    task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_dat_t wdata,
                             output wb_dat_t rdata);
        int waited;
        waited = 0;
        @(posedge sys_clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        @(negedge sys_clk);
        while (!wb_ack && waited < ACK_LIMIT) begin
            @(negedge sys_clk);
            waited++;
        end
        if (!wb_ack) begin
            errors++;
            $display("No Wishbone ack for address 0x%02h within %0d cycles", adr, ACK_LIMIT);
        end
        rdata = wb_dat_r;
        @(posedge sys_clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input wb_adr_t adr, input wb_dat_t data);
        wb_dat_t unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input wb_adr_t adr, output wb_dat_t data);
        bus_cycle(1'b0, adr, '0, data);
    endtask

    // Seed, enable, wait for count samples, disable
    task automatic run_stream(input string name, input lfsr_state_t seed,
                              input tap_sel_e tap, input gain_shift_t shift, input int count);
        int budget;
        test_name = name;
        got_a.delete();
        got_b.delete();
        wb_write(`ADDR_CTRL, ctrl_word(1'b0, tap, shift));
        wb_write(`ADDR_SEED, wb_dat_t'(seed));
        fill_symbols(seed, count / `SPS + 1);
        for (int k = 0; k < count; k++) begin
            exp_a.push_back(ref_dac_word(k, 1'b0, tap, shift));
            exp_b.push_back(ref_dac_word(k, 1'b1, tap, shift));
        end
        quiet = 1'b0;
        wb_write(`ADDR_CTRL, ctrl_word(1'b1, tap, shift));
        budget = (count + 4) * `SAMPLE_DIV + 16;
        while (exp_a.size() > 0 && budget > 0) begin
            @(posedge sys_clk);
            budget--;
        end
        if (exp_a.size() > 0) begin
            errors++;
            $display("%s: only %0d of %0d DAC samples arrived", name,
                     count - exp_a.size(), count);
            exp_a.delete();
            exp_b.delete();
        end
        wb_write(`ADDR_CTRL, ctrl_word(1'b0, tap, shift));
        // Last in-flight write has drained by now
        quiet = 1'b1;
    endtask

    // Compare on each DAC write, mid-cycle where outputs are settled
    always @(negedge sys_clk) begin
        if (arst_n && dac_wrt) begin
            if (exp_a.size() > 0) begin
                got_a.push_back(dac_a);
                got_b.push_back(dac_b);
                check_value({test_name, " rail a"}, exp_a.pop_front(), dac_a);
                check_value({test_name, " rail b"}, exp_b.pop_front(), dac_b);
            end else if (quiet) begin
                errors++;
                $display("DAC write strobe seen while transmitter disabled (%s)", test_name);
            end
        end
    end

    // Watchdog scaled from the total sample count
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("Watchdog expired before the tests finished");
        $display("Checks: %0d  Errors: %0d", checks, errors + 1);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        wb_dat_t     rdata;
        wb_dat_t     wdata;
        lfsr_state_t seed;
        gain_shift_t shift;
        dac_word_t   first_a [$];
        dac_word_t   first_b [$];
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        quiet     = 1'b1;
        test_name = "reset";
        @(posedge arst_n);

        // Idle outputs after reset
        for (int c = 0; c < 8; c++) begin
            @(negedge sys_clk);
            check_value("reset wb_ack", 0, wb_ack);
            check_value("reset dac_wrt", 0, dac_wrt);
            check_value("reset dac_a", 32'h2000, dac_a);
            check_value("reset dac_b", 32'h2000, dac_b);
        end

        // Register readback, enable kept low
        test_name = "registers";
        wdata = rand_bits(32) & ~32'h1;
        wb_write(`ADDR_CTRL, wdata);
        wb_read(`ADDR_CTRL, rdata);
        check_value("ctrl readback", wdata & 32'h1f, rdata);
        seed = lfsr_state_t'(rand_bits(32));
        wb_write(`ADDR_SEED, rand_bits(10) << `LFSR_W | wb_dat_t'(seed));
        wb_read(`ADDR_SEED, rdata);
        check_value("seed readback", wb_dat_t'(seed), rdata);
        // Unmapped slots, acked and empty
        wb_write(8'h08, rand_bits(32));
        wb_read(8'h08, rdata);
        check_value("unmapped 0x08 read", 0, rdata);
        wb_read(8'h0c, rdata);
        check_value("unmapped 0x0c read", 0, rdata);
        wb_read(`ADDR_CTRL, rdata);
        check_value("ctrl after unmapped write", wdata & 32'h1f, rdata);

        // Filtered stream, no gain shift
        seed = lfsr_state_t'(rand_bits(`LFSR_W));
        run_stream("filtered shift 0", seed, TAP_FILTERED, 2'd0, 64);

        for (int g = 1; g < 4; g++) begin
            seed = lfsr_state_t'(rand_bits(`LFSR_W));
            run_stream($sformatf("filtered shift %0d", g), seed, TAP_FILTERED,
                       gain_shift_t'(g), 64);
        end

        // Other tap points
        seed = lfsr_state_t'(rand_bits(`LFSR_W));
        shift = gain_shift_t'(rand_bits(2));
        run_stream("upsampled tap", seed, TAP_UPSAMPLED, shift, 32);
        seed = lfsr_state_t'(rand_bits(`LFSR_W));
        run_stream("symbol tap", seed, TAP_SYMBOL, 2'd0, 32);
        shift = gain_shift_t'(rand_bits(2));
        run_stream("zero tap", seed, TAP_ZERO, shift, 32);

        // Restart with the same seed repeats the stream
        seed = lfsr_state_t'(rand_bits(`LFSR_W));
        shift = gain_shift_t'(rand_bits(2));
        run_stream("restart first run", seed, TAP_FILTERED, shift, 32);
        first_a = got_a;
        first_b = got_b;
        repeat (40) @(posedge sys_clk);
        run_stream("restart second run", seed, TAP_FILTERED, shift, 32);
        check_value("restart length", first_a.size(), got_a.size());
        if (first_a.size() == got_a.size()) begin
            for (int i = 0; i < first_a.size(); i++) begin
                check_value("restart repeat rail a", first_a[i], got_a[i]);
                check_value("restart repeat rail b", first_b[i], got_b[i]);
            end
        end
        repeat (20) @(posedge sys_clk);

        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic sys_clk,
    output logic arst_n
);

    localparam int HALF_PERIOD_NS = 10;
    localparam int RESET_CYCLES   = 5;

    // 20 ns free-running clock
    initial begin
        sys_clk = 1'b0;
        forever #HALF_PERIOD_NS sys_clk = ~sys_clk;
    end

    // Reset held low, released just after an edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge sys_clk);
        #1;
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+logic
logic/qam_ctrl_pkg.sv
logic/qam_types_pkg.sv
logic/tx_csr_wb.sv
logic/tx_timing_gen.sv
logic/lfsr_symbol_source.sv
logic/qam16_mapper.sv
logic/srrc_interp_filter.sv
logic/dac_formatter.sv
logic/qam_tx_top.sv
tests/tb_clock_gen.sv
tests/qam_tx_tb.sv
